/* bus_ctrl_pkg.sv */
/* Board control package
   Widths, register map and state types shared by the register block */

package bus_ctrl_pkg;

   // ----------------------------------------
   // Word and address types
   // ----------------------------------------
   typedef logic [31:0] data_t;
   // Register index, AXI byte address bits 9:2
   typedef logic [7:0]  reg_addr_t;
   typedef logic [9:0]  axi_addr_t;

   // ----------------------------------------
   // Board pin groups
   // ----------------------------------------
   // {mod_abs, tx_fault, rx_los}
   typedef logic [2:0]  sfpp_pins_t;
   typedef logic [3:0]  fifo_flags_t;
   typedef logic [4:0]  clk_status_t;
   typedef logic [6:0]  clk_ctrl_t;
   // Rate-select pull-low enables {rs1, rs0}
   typedef logic [1:0]  sfpp_ctrl_t;

   // Channel FSMs
   typedef enum logic {wr_idle, wr_resp} wr_state_t;
   typedef enum logic {rd_idle, rd_data} rd_state_t;

   // Setting indexes
   localparam reg_addr_t SR_LEDS       = 8'd0;
   localparam reg_addr_t SR_SW_RST     = 8'd1;
   localparam reg_addr_t SR_CLOCK_CTRL = 8'd2;
   localparam reg_addr_t SR_SFPP_CTRL0 = 8'd8;
   localparam reg_addr_t SR_SFPP_CTRL1 = 8'd9;
   localparam reg_addr_t SR_FIFOFLAGS  = 8'd10;

   // Readback indexes
   localparam reg_addr_t RB_COUNTER      = 8'd0;
   localparam reg_addr_t RB_CLK_STATUS   = 8'd3;
   localparam reg_addr_t RB_COMPAT_NUM   = 8'd6;
   localparam reg_addr_t RB_SFPP_STATUS0 = 8'd8;
   localparam reg_addr_t RB_SFPP_STATUS1 = 8'd9;
   localparam reg_addr_t RB_FIFOFLAGS    = 8'd10;

   // Bit 6 high selects the GPSDO reference out of reset
   localparam clk_ctrl_t   CLK_CTRL_AT_RESET = 7'b1000000;
   localparam logic [15:0] COMPAT_MAJOR_DEF  = 16'd8;
   localparam logic [15:0] COMPAT_MINOR_DEF  = 16'd0;

   // AXI response code, every access answers OKAY
   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* axil_reg_decode.sv */
/* AXI4-Lite register decode
   Turns host writes and reads into setting and readback strobes */

`timescale 1ns/1ps

module axil_reg_decode (
   input  logic                      clk,
   input  logic                      reset,
   // Write address and data
   input  bus_ctrl_pkg::axi_addr_t   i_awaddr,
   input  logic                      i_awvalid,
   output logic                      o_awready,
   input  bus_ctrl_pkg::data_t       i_wdata,
   input  logic [3:0]                i_wstrb,
   input  logic                      i_wvalid,
   output logic                      o_wready,
   // Write response
   output logic [1:0]                o_bresp,
   output logic                      o_bvalid,
   input  logic                      i_bready,
   // Read address and data
   input  bus_ctrl_pkg::axi_addr_t   i_araddr,
   input  logic                      i_arvalid,
   output logic                      o_arready,
   output bus_ctrl_pkg::data_t       o_rdata,
   output logic [1:0]                o_rresp,
   output logic                      o_rvalid,
   input  logic                      i_rready,
   // Internal settings bus
   output logic                      o_set_stb,
   output bus_ctrl_pkg::reg_addr_t   o_set_addr,
   output bus_ctrl_pkg::data_t       o_set_data,
   // Internal readback bus
   output logic                      o_rb_stb,
   output bus_ctrl_pkg::reg_addr_t   o_rb_addr,
   input  bus_ctrl_pkg::data_t       i_rb_data,
   output logic [1:0]                o_sfpp_rd_ack
);

   bus_ctrl_pkg::wr_state_t   wr_state;
   bus_ctrl_pkg::rd_state_t   rd_state;
   logic                      wr_accept;
   logic                      rd_accept;
   bus_ctrl_pkg::reg_addr_t   rd_index;

   // ----------------------------------------
   // Write channel
   // ----------------------------------------
   // AW and W taken together, only when idle
   assign wr_accept = (wr_state == bus_ctrl_pkg::wr_idle) && i_awvalid && i_wvalid;
   assign o_awready = wr_accept;
   assign o_wready  = wr_accept;
   assign o_bresp   = bus_ctrl_pkg::RESP_OKAY;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_state  <= bus_ctrl_pkg::wr_idle;
         o_set_stb <= 1'b0;
         o_bvalid  <= 1'b0;
      end else begin
         o_set_stb <= wr_accept;
         case (wr_state)
            bus_ctrl_pkg::wr_idle: begin
               if (wr_accept)
                  wr_state <= bus_ctrl_pkg::wr_resp;
            end
            bus_ctrl_pkg::wr_resp: begin
               // Response follows the setting strobe by one cycle
               if (o_set_stb) begin
                  o_bvalid <= 1'b1;
               end else if (o_bvalid && i_bready) begin
                  o_bvalid <= 1'b0;
                  wr_state <= bus_ctrl_pkg::wr_idle;
               end
            end
            default: wr_state <= bus_ctrl_pkg::wr_idle;
         endcase
      end
   end

   // Byte address to word index
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         o_set_addr <= i_awaddr[9:2];
         o_set_data <= i_wdata;
      end
   end

   // ----------------------------------------
   // Read channel
   // ----------------------------------------
   assign rd_accept = (rd_state == bus_ctrl_pkg::rd_idle) && i_arvalid;
   assign rd_index  = i_araddr[9:2];
   assign o_arready = rd_accept;
   assign o_rresp   = bus_ctrl_pkg::RESP_OKAY;
   // Readback word holds until the next strobe, which waits for rready
   assign o_rdata   = i_rb_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_state      <= bus_ctrl_pkg::rd_idle;
         o_rb_stb      <= 1'b0;
         o_rvalid      <= 1'b0;
         o_sfpp_rd_ack <= 2'b00;
      end else begin
         o_rb_stb <= rd_accept;
         // Cage clears line up with the readback capture edge
         o_sfpp_rd_ack[0] <= rd_accept && (rd_index == bus_ctrl_pkg::RB_SFPP_STATUS0);
         o_sfpp_rd_ack[1] <= rd_accept && (rd_index == bus_ctrl_pkg::RB_SFPP_STATUS1);
         case (rd_state)
            bus_ctrl_pkg::rd_idle: begin
               if (rd_accept)
                  rd_state <= bus_ctrl_pkg::rd_data;
            end
            bus_ctrl_pkg::rd_data: begin
               if (o_rb_stb) begin
                  o_rvalid <= 1'b1;
               end else if (o_rvalid && i_rready) begin
                  o_rvalid <= 1'b0;
                  rd_state <= bus_ctrl_pkg::rd_idle;
               end
            end
            default: rd_state <= bus_ctrl_pkg::rd_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_accept)
         o_rb_addr <= rd_index;
   end

   // ----------------------------------------
   // Protocol checks
   // ----------------------------------------
   // Responses held until the master takes them
   a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      o_bvalid && !i_bready |=> o_bvalid);
   a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
      o_rvalid && !i_rready |=> o_rvalid);
   // Only full-word writes reach the settings
   a_full_word: assert property (@(posedge clk) disable iff (reset)
      wr_accept |-> i_wstrb == 4'hf);

endmodule

/* setting_bank.sv */
/* Setting register bank
   Loads LED, reset, clock and SFP+ settings and pulses the FIFO flag clear */

`timescale 1ns/1ps

module setting_bank #(
   parameter bus_ctrl_pkg::clk_ctrl_t CLK_CTRL_AT_RESET = bus_ctrl_pkg::CLK_CTRL_AT_RESET
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       i_set_stb,
   input  bus_ctrl_pkg::reg_addr_t    i_set_addr,
   input  bus_ctrl_pkg::data_t        i_set_data,
   output logic [7:0]                 o_leds,
   // [0] PHY, [1] radio domain, [2] radio PLL, [3] spare
   output logic [3:0]                 o_sw_rst,
   output bus_ctrl_pkg::clk_ctrl_t    o_clock_control,
   output bus_ctrl_pkg::sfpp_ctrl_t   o_sfpp0_ctrl,
   output bus_ctrl_pkg::sfpp_ctrl_t   o_sfpp1_ctrl,
   output logic                       o_flags_clear
);

   // ----------------------------------------
   // Setting registers
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         o_clock_control <= CLK_CTRL_AT_RESET;
         o_sfpp0_ctrl    <= '0;
         o_sfpp1_ctrl    <= '0;
      end else if (i_set_stb) begin
         // Each register takes the low bits of the word
         case (i_set_addr)
            bus_ctrl_pkg::SR_LEDS:
               o_leds <= i_set_data[7:0];
            bus_ctrl_pkg::SR_SW_RST:
               o_sw_rst <= i_set_data[3:0];
            bus_ctrl_pkg::SR_CLOCK_CTRL:
               o_clock_control <= i_set_data[6:0];
            // Rate-select pins driven low when bit set
            bus_ctrl_pkg::SR_SFPP_CTRL0:
               o_sfpp0_ctrl <= i_set_data[1:0];
            bus_ctrl_pkg::SR_SFPP_CTRL1:
               o_sfpp1_ctrl <= i_set_data[1:0];
            // Other indexes leave every register alone
            default: ;
         endcase
      end
   end

   // ----------------------------------------
   // FIFO flag clear
   // ----------------------------------------
   // Data word ignored, the write itself is the command
   always_ff @(posedge clk) begin
      if (reset)
         o_flags_clear <= 1'b0;
      else
         o_flags_clear <= i_set_stb && (i_set_addr == bus_ctrl_pkg::SR_FIFOFLAGS);
   end

   // Strobes are spaced by the write response, so the clear is one cycle
   a_clear_single: assert property (@(posedge clk) disable iff (reset)
      o_flags_clear |=> !o_flags_clear);

endmodule

/* sfpp_status_monitor.sv */
/* SFP+ status monitor
   Synchronizes cage status pins and latches level changes until read */

`timescale 1ns/1ps

module sfpp_status_monitor (
   input  logic                       clk,
   input  logic                       reset,
   input  bus_ctrl_pkg::sfpp_pins_t   i_sfpp0_pins,
   input  bus_ctrl_pkg::sfpp_pins_t   i_sfpp1_pins,
   input  logic [1:0]                 i_sfpp_rd_ack,
   output logic [5:0]                 o_sfpp0_status,
   output logic [5:0]                 o_sfpp1_status
);

   // Index 0 and 1 per cage
   bus_ctrl_pkg::sfpp_pins_t   pins   [2];
   bus_ctrl_pkg::sfpp_pins_t   sync1  [2];
   bus_ctrl_pkg::sfpp_pins_t   sync2  [2];
   // Previous synchronized level
   bus_ctrl_pkg::sfpp_pins_t   sync3  [2];
   bus_ctrl_pkg::sfpp_pins_t   chgd   [2];

   assign pins[0] = i_sfpp0_pins;
   assign pins[1] = i_sfpp1_pins;

   // ----------------------------------------
   // Per-cage synchronizer and change latch
   // ----------------------------------------
   for (genvar c = 0; c < 2; c++) begin : g_cage
      always_ff @(posedge clk) begin
         if (reset) begin
            sync1[c] <= '0;
            sync2[c] <= '0;
            sync3[c] <= '0;
            chgd[c]  <= '0;
         end else begin
            // Pins are asynchronous to clk
            sync1[c] <= pins[c];
            sync2[c] <= sync1[c];
            sync3[c] <= sync2[c];
            // Edge seen on the settled level only
            // Clear on read, a change in the same cycle survives
            chgd[c]  <= (chgd[c] & ~{3{i_sfpp_rd_ack[c]}}) | (sync2[c] ^ sync3[c]);
         end
      end
   end

   // {changed, level}
   assign o_sfpp0_status = {chgd[0], sync2[0]};
   assign o_sfpp1_status = {chgd[1], sync2[1]};

endmodule

/* status_readback.sv */
/* Status readback
   Counter, sticky FIFO faults and the registered readback word mux */

`timescale 1ns/1ps

module status_readback #(
   parameter logic [15:0] COMPAT_MAJOR = bus_ctrl_pkg::COMPAT_MAJOR_DEF,
   parameter logic [15:0] COMPAT_MINOR = bus_ctrl_pkg::COMPAT_MINOR_DEF
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        i_rb_stb,
   input  bus_ctrl_pkg::reg_addr_t     i_rb_addr,
   input  bus_ctrl_pkg::clk_status_t   i_clock_status,
   input  bus_ctrl_pkg::fifo_flags_t   i_fifo_flags,
   input  logic                        i_flags_clear,
   input  logic [5:0]                  i_sfpp0_status,
   input  logic [5:0]                  i_sfpp1_status,
   output bus_ctrl_pkg::data_t         o_rb_data
);

   bus_ctrl_pkg::data_t         counter;
   bus_ctrl_pkg::fifo_flags_t   fifo_sticky;
   bus_ctrl_pkg::data_t         rb_mux;

   // ----------------------------------------
   // Counter and FIFO fault flags
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset)
         counter <= '0;
      else
         counter <= counter + 32'd1;
   end

   // Flag inputs are active low
   // A fault seen during the clear is kept
   always_ff @(posedge clk) begin
      if (reset)
         fifo_sticky <= '0;
      else
         fifo_sticky <= (i_flags_clear ? '0 : fifo_sticky) | ~i_fifo_flags;
   end

   // ----------------------------------------
   // Readback mux
   // ----------------------------------------
   always_comb begin
      case (i_rb_addr)
         bus_ctrl_pkg::RB_COUNTER:      rb_mux = counter;
         bus_ctrl_pkg::RB_CLK_STATUS:   rb_mux = {27'd0, i_clock_status};
         bus_ctrl_pkg::RB_COMPAT_NUM:   rb_mux = {COMPAT_MAJOR, COMPAT_MINOR};
         bus_ctrl_pkg::RB_SFPP_STATUS0: rb_mux = {26'd0, i_sfpp0_status};
         bus_ctrl_pkg::RB_SFPP_STATUS1: rb_mux = {26'd0, i_sfpp1_status};
         bus_ctrl_pkg::RB_FIFOFLAGS:    rb_mux = {28'd0, fifo_sticky};
         // Unmapped reads as zero
         default:                       rb_mux = '0;
      endcase
   end

   // Captured once per read, held for the response
   always_ff @(posedge clk) begin
      if (i_rb_stb)
         o_rb_data <= rb_mux;
   end

   // Clear from the settings bank empties the flags when no fault is present
   a_flags_cleared: assert property (@(posedge clk) disable iff (reset)
      i_flags_clear && (&i_fifo_flags) |=> fifo_sticky == '0);

endmodule

/* bus_ctrl_top.sv */
/* Board control register block
   AXI4-Lite host port onto settings, SFP+ status and readback logic */

`timescale 1ns/1ps

module bus_ctrl_top #(
   parameter bus_ctrl_pkg::clk_ctrl_t CLK_CTRL_AT_RESET = bus_ctrl_pkg::CLK_CTRL_AT_RESET,
   parameter logic [15:0]             COMPAT_MAJOR      = bus_ctrl_pkg::COMPAT_MAJOR_DEF,
   parameter logic [15:0]             COMPAT_MINOR      = bus_ctrl_pkg::COMPAT_MINOR_DEF
) (
   input  logic                        clk,
   input  logic                        reset,
   // AXI4-Lite slave
   input  bus_ctrl_pkg::axi_addr_t     i_awaddr,
   input  logic                        i_awvalid,
   output logic                        o_awready,
   input  bus_ctrl_pkg::data_t         i_wdata,
   input  logic [3:0]                  i_wstrb,
   input  logic                        i_wvalid,
   output logic                        o_wready,
   output logic [1:0]                  o_bresp,
   output logic                        o_bvalid,
   input  logic                        i_bready,
   input  bus_ctrl_pkg::axi_addr_t     i_araddr,
   input  logic                        i_arvalid,
   output logic                        o_arready,
   output bus_ctrl_pkg::data_t         o_rdata,
   output logic [1:0]                  o_rresp,
   output logic                        o_rvalid,
   input  logic                        i_rready,
   // Board pins
   input  bus_ctrl_pkg::sfpp_pins_t    i_sfpp0_pins,
   input  bus_ctrl_pkg::sfpp_pins_t    i_sfpp1_pins,
   input  bus_ctrl_pkg::clk_status_t   i_clock_status,
   input  bus_ctrl_pkg::fifo_flags_t   i_fifo_flags,
   output logic [7:0]                  o_leds,
   output logic [3:0]                  o_sw_rst,
   output bus_ctrl_pkg::clk_ctrl_t     o_clock_control,
   output bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp0_ctrl,
   output bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp1_ctrl
);

   // Settings bus
   logic                       set_stb;
   bus_ctrl_pkg::reg_addr_t    set_addr;
   bus_ctrl_pkg::data_t        set_data;
   // Readback bus
   logic                       rb_stb;
   bus_ctrl_pkg::reg_addr_t    rb_addr;
   bus_ctrl_pkg::data_t        rb_data;
   // Status paths
   logic [1:0]                 sfpp_rd_ack;
   logic [5:0]                 sfpp0_status;
   logic [5:0]                 sfpp1_status;
   logic                       flags_clear;

   axil_reg_decode u_decode (
      .clk           (clk),
      .reset         (reset),
      .i_awaddr      (i_awaddr),
      .i_awvalid     (i_awvalid),
      .o_awready     (o_awready),
      .i_wdata       (i_wdata),
      .i_wstrb       (i_wstrb),
      .i_wvalid      (i_wvalid),
      .o_wready      (o_wready),
      .o_bresp       (o_bresp),
      .o_bvalid      (o_bvalid),
      .i_bready      (i_bready),
      .i_araddr      (i_araddr),
      .i_arvalid     (i_arvalid),
      .o_arready     (o_arready),
      .o_rdata       (o_rdata),
      .o_rresp       (o_rresp),
      .o_rvalid      (o_rvalid),
      .i_rready      (i_rready),
      .o_set_stb     (set_stb),
      .o_set_addr    (set_addr),
      .o_set_data    (set_data),
      .o_rb_stb      (rb_stb),
      .o_rb_addr     (rb_addr),
      .i_rb_data     (rb_data),
      .o_sfpp_rd_ack (sfpp_rd_ack)
   );

   setting_bank #(
      .CLK_CTRL_AT_RESET (CLK_CTRL_AT_RESET)
   ) u_settings (
      .clk             (clk),
      .reset           (reset),
      .i_set_stb       (set_stb),
      .i_set_addr      (set_addr),
      .i_set_data      (set_data),
      .o_leds          (o_leds),
      .o_sw_rst        (o_sw_rst),
      .o_clock_control (o_clock_control),
      .o_sfpp0_ctrl    (o_sfpp0_ctrl),
      .o_sfpp1_ctrl    (o_sfpp1_ctrl),
      .o_flags_clear   (flags_clear)
   );

   sfpp_status_monitor u_sfpp (
      .clk            (clk),
      .reset          (reset),
      .i_sfpp0_pins   (i_sfpp0_pins),
      .i_sfpp1_pins   (i_sfpp1_pins),
      .i_sfpp_rd_ack  (sfpp_rd_ack),
      .o_sfpp0_status (sfpp0_status),
      .o_sfpp1_status (sfpp1_status)
   );

   status_readback #(
      .COMPAT_MAJOR (COMPAT_MAJOR),
      .COMPAT_MINOR (COMPAT_MINOR)
   ) u_readback (
      .clk            (clk),
      .reset          (reset),
      .i_rb_stb       (rb_stb),
      .i_rb_addr      (rb_addr),
      .i_clock_status (i_clock_status),
      .i_fifo_flags   (i_fifo_flags),
      .i_flags_clear  (flags_clear),
      .i_sfpp0_status (sfpp0_status),
      .i_sfpp1_status (sfpp1_status),
      .o_rb_data      (rb_data)
   );

endmodule

/* tb_bus_ctrl.sv */
/* Board control testbench
   Runs host writes, reads and pin events from the stimulus file */

`timescale 1ns/1ps

module tb_bus_ctrl;

   logic                        clk;
   logic                        reset;
   bus_ctrl_pkg::axi_addr_t     i_awaddr;
   logic                        i_awvalid;
   bus_ctrl_pkg::data_t         i_wdata;
   logic [3:0]                  i_wstrb;
   logic                        i_wvalid;
   logic                        i_bready;
   bus_ctrl_pkg::axi_addr_t     i_araddr;
   logic                        i_arvalid;
   logic                        i_rready;
   bus_ctrl_pkg::sfpp_pins_t    i_sfpp0_pins;
   bus_ctrl_pkg::sfpp_pins_t    i_sfpp1_pins;
   bus_ctrl_pkg::clk_status_t   i_clock_status;
   bus_ctrl_pkg::fifo_flags_t   i_fifo_flags;
   logic                        o_awready;
   logic                        o_wready;
   logic [1:0]                  o_bresp;
   logic                        o_bvalid;
   logic                        o_arready;
   bus_ctrl_pkg::data_t         o_rdata;
   logic [1:0]                  o_rresp;
   logic                        o_rvalid;
   logic [7:0]                  o_leds;
   logic [3:0]                  o_sw_rst;
   bus_ctrl_pkg::clk_ctrl_t     o_clock_control;
   bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp0_ctrl;
   bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp1_ctrl;
   int                          cycle_count = 0;
   // Zero until the stimulus length is known
   int                          cycle_limit = 0;
   bus_ctrl_pkg::data_t         last_count;

   bus_ctrl_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ----------------------------------------
   // Failure and compare tasks
   // ----------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input bus_ctrl_pkg::data_t exp,
                             input bus_ctrl_pkg::data_t act);
      if (act !== exp) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         abort_run("readback word wrong");
      end
   endtask

   task automatic check_clk_ctrl(input string name, input bus_ctrl_pkg::clk_ctrl_t exp,
                                 input bus_ctrl_pkg::clk_ctrl_t act);
      if (act !== exp) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         abort_run("clock control output wrong");
      end
   endtask

   task automatic check_sfpp_ctrl(input string name, input bus_ctrl_pkg::sfpp_ctrl_t exp,
                                  input bus_ctrl_pkg::sfpp_ctrl_t act);
      if (act !== exp) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         abort_run("SFP+ control output wrong");
      end
   endtask

   // LEDs, software resets and response codes, zero-extended to 8 bits
   task automatic check_bits(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         abort_run("output bits wrong");
      end
   endtask

   // Watchdog on the whole run
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
         abort_run("watchdog expired, a handshake hung");
   end

   // ----------------------------------------
   // Bus tasks
   // ----------------------------------------
   // Inputs change 2 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic axi_write(input bus_ctrl_pkg::axi_addr_t addr, input bus_ctrl_pkg::data_t data);
      int unsigned stall;
      logic        taken;
      stall     = $urandom % 4;
      taken     = 1'b0;
      i_awaddr  = addr;
      i_wdata   = data;
      i_wstrb   = 4'hf;
      i_awvalid = 1'b1;
      i_wvalid  = 1'b1;
      i_bready  = 1'b0;
      // Ready sampled mid-cycle, where it is settled
      while (!taken) begin
         @(negedge clk);
         taken = o_awready && o_wready;
         next_cycle();
      end
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      while (!o_bvalid)
         next_cycle();
      check_bits("write_bresp", 8'd0, {6'd0, o_bresp});
      // Host stall on bready
      repeat (stall) begin
         next_cycle();
         if (!o_bvalid)
            abort_run("write response dropped before bready");
      end
      i_bready = 1'b1;
      next_cycle();
      i_bready = 1'b0;
      if (o_bvalid)
         abort_run("write response repeated after handshake");
   endtask

   task automatic axi_read(input bus_ctrl_pkg::axi_addr_t addr, output bus_ctrl_pkg::data_t data);
      int unsigned stall;
      logic        taken;
      stall     = $urandom % 4;
      taken     = 1'b0;
      i_araddr  = addr;
      i_arvalid = 1'b1;
      i_rready  = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = o_arready;
         next_cycle();
      end
      i_arvalid = 1'b0;
      while (!o_rvalid)
         next_cycle();
      data = o_rdata;
      check_bits("read_rresp", 8'd0, {6'd0, o_rresp});
      // Word must hold while the host stalls
      repeat (stall) begin
         next_cycle();
         if (!o_rvalid)
            abort_run("read response dropped before rready");
         if (o_rdata !== data)
            abort_run("read data changed while rready was low");
      end
      i_rready = 1'b1;
      next_cycle();
      i_rready = 1'b0;
      if (o_rvalid)
         abort_run("read response repeated after handshake");
   endtask

   // ----------------------------------------
   // One stimulus step
   // ----------------------------------------
   task automatic run_step(input string op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input string name);
      bus_ctrl_pkg::reg_addr_t   idx;
      bus_ctrl_pkg::data_t       rd;
      idx = addr[9:2];
      if (op == "write") begin
         axi_write(addr[9:0], data);
         // Output already updated when bvalid is seen
         if (idx == bus_ctrl_pkg::SR_LEDS)
            check_bits(name, exp[7:0], o_leds);
         else if (idx == bus_ctrl_pkg::SR_SW_RST)
            check_bits(name, exp[7:0], {4'd0, o_sw_rst});
         else if (idx == bus_ctrl_pkg::SR_CLOCK_CTRL)
            check_clk_ctrl(name, exp[6:0], o_clock_control);
         else if (idx == bus_ctrl_pkg::SR_SFPP_CTRL0)
            check_sfpp_ctrl(name, exp[1:0], o_sfpp0_ctrl);
         else if (idx == bus_ctrl_pkg::SR_SFPP_CTRL1)
            check_sfpp_ctrl(name, exp[1:0], o_sfpp1_ctrl);
      end else if (op == "read") begin
         axi_read(addr[9:0], rd);
         // Counter has no fixed value, only order
         if (idx == bus_ctrl_pkg::RB_COUNTER) begin
            if (rd <= last_count) begin
               $display("mismatch %s expected above %h actual %h", name, last_count, rd);
               abort_run("counter did not increase");
            end
            last_count = rd;
         end else begin
            check_data(name, exp, rd);
         end
      end else if (op == "pins") begin
         if (addr == 32'd0)
            i_sfpp0_pins = data[2:0];
         else if (addr == 32'd1)
            i_sfpp1_pins = data[2:0];
         else
            i_clock_status = data[4:0];
         next_cycle();
      end else if (op == "flags") begin
         i_fifo_flags = data[3:0];
         next_cycle();
      end else if (op == "delay") begin
         repeat (data) next_cycle();
      end else begin
         abort_run("unknown operation in stimulus file");
      end
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      int            fd;
      int            r;
      int            n_lines;
      int            steps_run;
      logic          done;
      string         op;
      string         name;
      string         line;
      logic [31:0]   f_addr;
      logic [31:0]   f_data;
      logic [31:0]   f_exp;
      void'($urandom(52));
      reset          = 1'b1;
      i_awaddr       = '0;
      i_awvalid      = 1'b0;
      i_wdata        = '0;
      i_wstrb        = 4'h0;
      i_wvalid       = 1'b0;
      i_bready       = 1'b0;
      i_araddr       = '0;
      i_arvalid      = 1'b0;
      i_rready       = 1'b0;
      i_sfpp0_pins   = '0;
      i_sfpp1_pins   = '0;
      i_clock_status = '0;
      // FIFO flags idle high
      i_fifo_flags   = 4'hf;
      last_count     = '0;
      steps_run      = 0;
      n_lines        = 0;
      // First pass sizes the watchdog
      fd = $fopen("bus_ctrl_stimulus.txt", "r");
      if (fd == 0)
         abort_run("cannot open stimulus file bus_ctrl_stimulus.txt");
      while (!$feof(fd)) begin
         r = $fgets(line, fd);
         if (r > 0)
            n_lines++;
      end
      $fclose(fd);
      cycle_limit = 40 * (n_lines + 1);
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      // State straight out of reset
      check_clk_ctrl("reset_clock_ctrl", 7'b1000000, o_clock_control);
      check_bits("reset_leds", 8'd0, o_leds);
      check_bits("reset_sw_rst", 8'd0, {4'd0, o_sw_rst});
      check_sfpp_ctrl("reset_sfpp0_ctrl", 2'b00, o_sfpp0_ctrl);
      check_sfpp_ctrl("reset_sfpp1_ctrl", 2'b00, o_sfpp1_ctrl);
      check_bits("reset_valids", 8'd0, {6'd0, o_bvalid, o_rvalid});
      fd = $fopen("bus_ctrl_stimulus.txt", "r");
      done = 1'b0;
      while (!done) begin
         r = $fscanf(fd, "%s", op);
         if (r != 1) begin
            done = 1'b1;
         end else if (op.substr(0, 0) == "#") begin
            r = $fgets(line, fd);
         end else begin
            r = $fscanf(fd, "%h %h %h %s", f_addr, f_data, f_exp, name);
            if (r != 4)
               abort_run("malformed line in stimulus file");
            run_step(op, f_addr, f_data, f_exp, name);
            steps_run++;
         end
      end
      $fclose(fd);
      if (steps_run > 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         abort_run("stimulus file held no steps");
      end
   end

endmodule

/* bus_ctrl_stimulus.txt */
# op addr data expected name, all numbers hex, addr is the AXI byte address
# pins addr 0 and 1 pick the SFP+ cage, 2 the clock status; delay data is cycles
write 000 000001a5 000000a5 leds_write
write 004 fffffff3 00000003 sw_rst_write
write 008 ffffff25 00000025 clock_ctrl_write
write 020 00000003 00000003 sfpp0_ctrl_write
write 024 fffffffe 00000002 sfpp1_ctrl_write
read 018 0 00080000 compat_num
pins 002 00000015 0 clock_status_set
read 00c 0 00000015 clock_status
read 010 0 00000000 unmapped_read
read 3fc 0 00000000 unmapped_top
read 000 0 0 counter_first
read 000 0 0 counter_second
pins 000 00000005 0 sfpp0_pins_set
delay 0 5 0 sfpp_settle
read 020 0 0000002d sfpp0_changed
read 020 0 00000005 sfpp0_cleared
read 024 0 00000000 sfpp1_untouched
flags 0 0000000b 0 fifo_flag_low
flags 0 0000000f 0 fifo_flag_high
read 028 0 00000004 fifo_sticky_set
write 028 0 0 fifo_clear
read 028 0 00000000 fifo_sticky_cleared
write 000 0000005a 0000005a leds_rewrite
read 018 0 00080000 compat_again
read 00c 0 00000015 clock_status_again
read 000 0 0 counter_third

/* tb.f */
bus_ctrl_pkg.sv
axil_reg_decode.sv
setting_bank.sv
sfpp_status_monitor.sv
status_readback.sv
bus_ctrl_top.sv
tb_bus_ctrl.sv

/* Makefile */
# Verilator build and run of the board control testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_ctrl
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
